// File: hdl/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

  // adder input a
  typedef enum logic {
    src_a_rs1,
    src_a_pc
  } src_a_e;

  // register writeback source
  typedef enum logic [1:0] {
    wb_sum,
    wb_pc4,
    wb_load
  } wb_sel_e;

  // run until ebreak, then stay halted
  typedef enum logic {
    st_run,
    st_halted
  } core_state_e;

endpackage

`default_nettype wire

// File: hdl/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  src_a_e  src_a;
  word_t   imm;
  wb_sel_e wb_sel;
  logic    reg_we;
  logic    mem_re;
  logic    mem_we;
  funct3_t funct3;
  logic    is_jump;
  logic    is_ebreak;

  // decoder drives everything
  modport dec (
    output src_a, imm, wb_sel, reg_we, mem_re, mem_we, funct3, is_jump, is_ebreak
  );
  modport exe (input src_a, imm, wb_sel);
  modport lsu (input mem_re, mem_we, funct3);
  modport pcu (input is_jump, is_ebreak);

endinterface

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  decode_if.exe             exe,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t pc_plus4,
  input  rv_isa_pkg::word_t load_data,
  output rv_isa_pkg::word_t sum,
  output rv_isa_pkg::word_t wdata
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  word_t op_a;

  // single adder: addi, lui, auipc, jump targets, load/store address
  assign op_a = (exe.src_a == src_a_pc) ? pc : rs1_data;
  assign sum  = op_a + exe.imm;

  always_comb begin
    case (exe.wb_sel)
      // link address for jal and jalr
      wb_pc4:  wdata = pc_plus4;
      wb_load: wdata = load_data;
      default: wdata = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  rv_isa_pkg::word_t     inst,
  input  logic                  commit_en,
  decode_if.dec                 dec,
  output rv_isa_pkg::reg_addr_t rs1_addr,
  output rv_isa_pkg::reg_addr_t rs2_addr,
  output rv_isa_pkg::reg_addr_t rd_addr
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  word_t   imm_j;
  logic    reg_we_raw;
  logic    mem_we_raw;

  assign opcode = opcode_t'(inst[6:0]);

  // lui adds its immediate to x0
  assign rs1_addr = (opcode == op_lui) ? '0 : inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  // immediates, all sign-extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // defaults: no side effects
    dec.src_a     = src_a_rs1;
    dec.imm       = imm_i;
    dec.wb_sel    = wb_sum;
    dec.mem_re    = 1'b0;
    dec.is_jump   = 1'b0;
    dec.is_ebreak = 1'b0;
    reg_we_raw    = 1'b0;
    mem_we_raw    = 1'b0;
    case (opcode)
      op_imm: reg_we_raw = 1'b1;
      op_lui: begin
        dec.imm    = imm_u;
        reg_we_raw = 1'b1;
      end
      op_auipc: begin
        dec.src_a  = src_a_pc;
        dec.imm    = imm_u;
        reg_we_raw = 1'b1;
      end
      op_jal: begin
        dec.src_a   = src_a_pc;
        dec.imm     = imm_j;
        dec.wb_sel  = wb_pc4;
        dec.is_jump = 1'b1;
        reg_we_raw  = 1'b1;
      end
      op_jalr: begin
        dec.wb_sel  = wb_pc4;
        dec.is_jump = 1'b1;
        reg_we_raw  = 1'b1;
      end
      op_load: begin
        dec.wb_sel = wb_load;
        dec.mem_re = 1'b1;
        reg_we_raw = 1'b1;
      end
      op_store: begin
        dec.imm    = imm_s;
        mem_we_raw = 1'b1;
      end
      // only ebreak is recognised among system encodings
      op_system: dec.is_ebreak = (inst[31:7] == 25'h0002000);
      default: ;
    endcase
  end

  // writes suppressed once halted
  assign dec.reg_we = reg_we_raw & commit_en;
  assign dec.mem_we = mem_we_raw & commit_en;
  assign dec.funct3 = inst[14:12];

endmodule

`default_nettype wire

// File: hdl/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  decode_if.lsu             lsu,
  input  rv_isa_pkg::word_t addr,
  input  rv_isa_pkg::word_t rs2_data,
  input  rv_isa_pkg::word_t mem_rdata,
  output rv_isa_pkg::strb_t mem_strb,
  output rv_isa_pkg::word_t mem_wdata,
  output logic              mem_re,
  output rv_isa_pkg::word_t load_data
);
  import rv_isa_pkg::*;

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  word_t       rd_shift;

  assign mem_re = lsu.mem_re;

  // store data replicated across lanes, strobe picks the lane
  always_comb begin
    mem_strb = '0;
    case (lsu.funct3)
      f3_byte: begin
        mem_wdata = {4{rs2_data[7:0]}};
        mem_strb  = strb_t'(4'b0001 << addr[1:0]);
      end
      f3_half: begin
        mem_wdata = {2{rs2_data[15:0]}};
        mem_strb  = addr[1] ? 4'b1100 : 4'b0011;
      end
      f3_word: begin
        mem_wdata = rs2_data;
        mem_strb  = 4'b1111;
      end
      default: mem_wdata = rs2_data;
    endcase
    // no strobe without a write
    if (!lsu.mem_we) begin
      mem_strb = '0;
    end
  end

  // lane select by address offset
  assign rd_shift = mem_rdata >> {addr[1:0], 3'b000};
  assign ld_byte  = rd_shift[7:0];
  assign ld_half  = addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (lsu.funct3)
      f3_byte:  load_data = {{24{ld_byte[7]}}, ld_byte};
      f3_half:  load_data = {{16{ld_half[15]}}, ld_half};
      f3_word:  load_data = mem_rdata;
      f3_byteu: load_data = {24'h000000, ld_byte};
      f3_halfu: load_data = {16'h0000, ld_half};
      default:  load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter rv_isa_pkg::word_t reset_pc = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              arst_n,
  decode_if.pcu             pcu,
  input  rv_isa_pkg::word_t target,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t pc_plus4,
  output logic              commit_en,
  output logic              halted
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  core_state_e state;
  word_t       pc_next;

  assign pc_plus4 = pc + 32'd4;
  // jalr may produce an odd target
  assign pc_next  = pcu.is_jump ? {target[31:1], 1'b0} : pc_plus4;

  assign commit_en = (state == st_run);
  assign halted    = (state == st_halted);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_run;
      pc    <= reset_pc;
    end else if (state == st_run) begin
      // pc parks on the ebreak
      if (pcu.is_ebreak) begin
        state <= st_halted;
      end else begin
        pc <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                  clk,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::reg_addr_t rd_addr,
  input  rv_isa_pkg::word_t     wdata,
  input  logic                  we,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;

  word_t regs [32];

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (we && rd_addr != '0) begin
      regs[rd_addr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter rv_isa_pkg::word_t reset_pc = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_isa_pkg::word_t inst,
  input  rv_isa_pkg::word_t mem_rdata,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t mem_addr,
  output rv_isa_pkg::word_t mem_wdata,
  output rv_isa_pkg::strb_t mem_strb,
  output logic              mem_we,
  output logic              mem_re,
  output logic              halted
);
  import rv_isa_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     wdata;
  word_t     sum;
  word_t     pc_plus4;
  word_t     load_data;
  logic      commit_en;

  decode_if dec_bus ();

  instr_decoder instr_decoder_i (
    .inst      (inst),
    .commit_en (commit_en),
    .dec       (dec_bus.dec),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .wdata    (wdata),
    .we       (dec_bus.reg_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  pc_unit #(
    .reset_pc (reset_pc)
  ) pc_unit_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .pcu       (dec_bus.pcu),
    .target    (sum),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .commit_en (commit_en),
    .halted    (halted)
  );

  exec_unit exec_unit_i (
    .exe       (dec_bus.exe),
    .rs1_data  (rs1_data),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .load_data (load_data),
    .sum       (sum),
    .wdata     (wdata)
  );

  // adder output doubles as the data address
  load_store_unit load_store_unit_i (
    .lsu       (dec_bus.lsu),
    .addr      (sum),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .mem_strb  (mem_strb),
    .mem_wdata (mem_wdata),
    .mem_re    (mem_re),
    .load_data (load_data)
  );

  assign mem_addr = sum;
  assign mem_we   = dec_bus.mem_we;

endmodule

`default_nettype wire

// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // data and address width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [2:0] funct3_t;

  // one enable bit per byte lane
  typedef logic [3:0] strb_t;

  // opcodes handled by this core, others decode as no-op
  typedef enum logic [6:0] {
    op_imm    = 7'b001_0011,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_system = 7'b111_0011
  } opcode_t;

  // load and store width codes in funct3
  localparam funct3_t f3_byte  = 3'b000;
  localparam funct3_t f3_half  = 3'b001;
  localparam funct3_t f3_word  = 3'b010;
  localparam funct3_t f3_byteu = 3'b100;
  localparam funct3_t f3_halfu = 3'b101;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb \
  -f rv_core_top.f -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: rv_core_top.f
hdl/rv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/decode_if.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/pc_unit.sv
hdl/exec_unit.sv
hdl/load_store_unit.sv
hdl/rv_core_top.sv
test/rv_core_checker.sv
test/rv_core_assertions.sv
test/rv_core_tb.sv

// File: test/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
  input logic              clk,
  input logic              arst_n,
  input rv_isa_pkg::word_t pc,
  input logic              halted
);

  // firing tally, read by the testbench at the end
  int fire_count = 0;

  // halted core parks its pc
  pc_frozen: assert property (@(posedge clk) disable iff (!arst_n) halted |=> $stable(pc))
    else begin
      $error("pc moved while the core was halted");
      fire_count++;
    end

  // only reset leaves halted
  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
      $error("halted fell without a reset");
      fire_count++;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");
      fire_count++;
    end

endmodule

bind pc_unit rv_core_assertions pc_checks (
  .clk    (clk),
  .arst_n (arst_n),
  .pc     (pc),
  .halted (halted)
);

`default_nettype wire

// File: test/rv_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
  input  logic              clk,
  input  logic              check_en,
  input  logic              done,
  input  int                step_idx,
  input  logic [63:0]       step_name,
  input  rv_isa_pkg::word_t exp_pc,
  input  logic              exp_we,
  input  logic              exp_re,
  input  rv_isa_pkg::word_t exp_addr,
  input  rv_isa_pkg::strb_t exp_strb,
  input  rv_isa_pkg::word_t exp_wdata,
  input  logic              exp_halted,
  input  rv_isa_pkg::word_t pc,
  input  logic              mem_we,
  input  logic              mem_re,
  input  rv_isa_pkg::word_t mem_addr,
  input  rv_isa_pkg::strb_t mem_strb,
  input  rv_isa_pkg::word_t mem_wdata,
  input  logic              halted,
  output int                pass_count,
  output int                fail_count
);
  import rv_isa_pkg::*;

  int passes = 0;
  int fails  = 0;
  // wrong fields in the step being checked
  int bad;

  assign pass_count = passes;
  assign fail_count = fails;

  task automatic compare(input string field, input word_t got, input word_t want);
    if (got !== want) begin
      $display("MISMATCH at %0t: step %0d %s, %s is %h, expected %h",
               $time, step_idx, step_name, field, got, want);
      bad++;
    end
  endtask

  // mid-cycle sample, well after the +1 ns drive and before the next edge
  always @(negedge clk) begin
    if (check_en) begin
      bad = 0;
      compare("pc", pc, exp_pc);
      compare("mem_we", word_t'(mem_we), word_t'(exp_we));
      compare("mem_re", word_t'(mem_re), word_t'(exp_re));
      compare("mem_strb", word_t'(mem_strb), word_t'(exp_strb));
      compare("halted", word_t'(halted), word_t'(exp_halted));
      // address only means something on a load or store
      if (exp_we || exp_re) begin
        compare("mem_addr", mem_addr, exp_addr);
      end
      // write data only on a store
      if (exp_we) begin
        compare("mem_wdata", mem_wdata, exp_wdata);
      end
      if (bad == 0) begin
        passes++;
        $display("step %0d %s: ok", step_idx, step_name);
      end else begin
        fails++;
        $display("step %0d %s: %0d wrong field(s)", step_idx, step_name, bad);
      end
    end
  end

  always @(posedge done) begin
    $display("checker: %0d steps passed, %0d failed", passes, fails);
  end

endmodule

`default_nettype wire

// File: test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  import rv_isa_pkg::*;

  localparam int num_steps      = 48;
  localparam int reset_cycles   = 2;
  localparam int timeout_margin = 20;
  localparam int cycle_limit    = num_steps + reset_cycles + timeout_margin;
  localparam logic [31:0] seed  = 32'h0dbc_a2bb;

  // one row: instruction, name, then expected port values
  typedef struct packed {
    word_t       inst;
    logic [63:0] name;
    word_t       pc;
    logic        we;
    logic        re;
    word_t       addr;
    strb_t       strb;
    word_t       wdata;
    logic        halted;
  } step_t;

  logic  clk;
  logic  arst_n;
  word_t inst;
  word_t mem_rdata;
  word_t pc;
  word_t mem_addr;
  word_t mem_wdata;
  strb_t mem_strb;
  logic  mem_we;
  logic  mem_re;
  logic  halted;
  logic  check_en;
  logic  done;
  int    cur_idx;
  step_t cur;
  step_t steps [num_steps];
  int    fill;
  int    cycles = 0;
  int    pass_count;
  int    fail_count;
  // 16-word data memory, aliased over the address space
  word_t mem [16];

  rv_core_top #(
    .reset_pc (32'h8000_0000)
  ) rv_core_top_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .inst      (inst),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_strb  (mem_strb),
    .mem_we    (mem_we),
    .mem_re    (mem_re),
    .halted    (halted)
  );

  rv_core_checker checker_i (
    .clk        (clk),
    .check_en   (check_en),
    .done       (done),
    .step_idx   (cur_idx),
    .step_name  (cur.name),
    .exp_pc     (cur.pc),
    .exp_we     (cur.we),
    .exp_re     (cur.re),
    .exp_addr   (cur.addr),
    .exp_strb   (cur.strb),
    .exp_wdata  (cur.wdata),
    .exp_halted (cur.halted),
    .pc         (pc),
    .mem_we     (mem_we),
    .mem_re     (mem_re),
    .mem_addr   (mem_addr),
    .mem_strb   (mem_strb),
    .mem_wdata  (mem_wdata),
    .halted     (halted),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  always #5 clk = ~clk;

  // combinational read, byte-masked write at the edge
  assign mem_rdata = mem[mem_addr[5:2]];

  always @(posedge clk) begin
    if (mem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_strb[b]) begin
          mem[mem_addr[5:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  // guard against a stuck run
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic plain_step(input word_t i, input logic [63:0] n, input word_t p,
                            input logic h);
    steps[fill] = '{i, n, p, 1'b0, 1'b0, 32'h0, 4'h0, 32'h0, h};
    fill++;
  endtask

  task automatic load_step(input word_t i, input logic [63:0] n, input word_t p,
                           input word_t a);
    steps[fill] = '{i, n, p, 1'b0, 1'b1, a, 4'h0, 32'h0, 1'b0};
    fill++;
  endtask

  task automatic store_step(input word_t i, input logic [63:0] n, input word_t p,
                            input word_t a, input strb_t s, input word_t d);
    steps[fill] = '{i, n, p, 1'b1, 1'b0, a, s, d, 1'b0};
    fill++;
  endtask

  task automatic build_table();
    // x1 = 0x12345678, x2 = 0x100 data base
    plain_step(32'h1234_50B7, "lui x1", 32'h8000_0000, 1'b0);
    plain_step(32'h6780_8093, "addi x1", 32'h8000_0004, 1'b0);
    plain_step(32'h1000_0113, "addi x2", 32'h8000_0008, 1'b0);
    store_step(32'h0011_2023, "sw x1", 32'h8000_000C, 32'h100, 4'b1111, 32'h1234_5678);
    // pc-relative value, then jal link
    plain_step(32'h0000_1197, "auipc", 32'h8000_0010, 1'b0);
    plain_step(32'h0041_8193, "addi x3", 32'h8000_0014, 1'b0);
    store_step(32'h0031_2223, "sw x3", 32'h8000_0018, 32'h104, 4'b1111, 32'h8000_1014);
    plain_step(32'h1000_026F, "jal", 32'h8000_001C, 1'b0);
    store_step(32'h0041_2423, "sw x4", 32'h8000_011C, 32'h108, 4'b1111, 32'h8000_0020);
    // jalr to 0x80000041, bit 0 dropped
    plain_step(32'h8000_02B7, "lui x5", 32'h8000_0120, 1'b0);
    plain_step(32'h0412_8367, "jalr", 32'h8000_0124, 1'b0);
    store_step(32'h0061_2623, "sw x6", 32'h8000_0040, 32'h10C, 4'b1111, 32'h8000_0128);
    // loads from 0x120 = f13c7f85, each stored back to 0x110
    load_step(32'h0201_0383, "lb+0", 32'h8000_0044, 32'h120);
    store_step(32'h0071_2823, "sw lb0", 32'h8000_0048, 32'h110, 4'b1111, 32'hFFFF_FF85);
    load_step(32'h0211_0383, "lb+1", 32'h8000_004C, 32'h121);
    store_step(32'h0071_2823, "sw lb1", 32'h8000_0050, 32'h110, 4'b1111, 32'h0000_007F);
    load_step(32'h0221_0383, "lb+2", 32'h8000_0054, 32'h122);
    store_step(32'h0071_2823, "sw lb2", 32'h8000_0058, 32'h110, 4'b1111, 32'h0000_003C);
    load_step(32'h0231_0383, "lb+3", 32'h8000_005C, 32'h123);
    store_step(32'h0071_2823, "sw lb3", 32'h8000_0060, 32'h110, 4'b1111, 32'hFFFF_FFF1);
    load_step(32'h0201_4383, "lbu+0", 32'h8000_0064, 32'h120);
    store_step(32'h0071_2823, "sw lbu0", 32'h8000_0068, 32'h110, 4'b1111, 32'h0000_0085);
    load_step(32'h0211_4383, "lbu+1", 32'h8000_006C, 32'h121);
    store_step(32'h0071_2823, "sw lbu1", 32'h8000_0070, 32'h110, 4'b1111, 32'h0000_007F);
    load_step(32'h0221_4383, "lbu+2", 32'h8000_0074, 32'h122);
    store_step(32'h0071_2823, "sw lbu2", 32'h8000_0078, 32'h110, 4'b1111, 32'h0000_003C);
    load_step(32'h0231_4383, "lbu+3", 32'h8000_007C, 32'h123);
    store_step(32'h0071_2823, "sw lbu3", 32'h8000_0080, 32'h110, 4'b1111, 32'h0000_00F1);
    load_step(32'h0201_1383, "lh+0", 32'h8000_0084, 32'h120);
    store_step(32'h0071_2823, "sw lh0", 32'h8000_0088, 32'h110, 4'b1111, 32'h0000_7F85);
    load_step(32'h0221_1383, "lh+2", 32'h8000_008C, 32'h122);
    store_step(32'h0071_2823, "sw lh2", 32'h8000_0090, 32'h110, 4'b1111, 32'hFFFF_F13C);
    load_step(32'h0201_5383, "lhu+0", 32'h8000_0094, 32'h120);
    store_step(32'h0071_2823, "sw lhu0", 32'h8000_0098, 32'h110, 4'b1111, 32'h0000_7F85);
    load_step(32'h0221_5383, "lhu+2", 32'h8000_009C, 32'h122);
    store_step(32'h0071_2823, "sw lhu2", 32'h8000_00A0, 32'h110, 4'b1111, 32'h0000_F13C);
    load_step(32'h0201_2383, "lw", 32'h8000_00A4, 32'h120);
    store_step(32'h0071_2823, "sw lw", 32'h8000_00A8, 32'h110, 4'b1111, 32'hF13C_7F85);
    // sub-word stores of x1, replicated across lanes
    store_step(32'h0011_0A23, "sb+0", 32'h8000_00AC, 32'h114, 4'b0001, 32'h7878_7878);
    store_step(32'h0011_0AA3, "sb+1", 32'h8000_00B0, 32'h115, 4'b0010, 32'h7878_7878);
    store_step(32'h0011_0B23, "sb+2", 32'h8000_00B4, 32'h116, 4'b0100, 32'h7878_7878);
    store_step(32'h0011_0BA3, "sb+3", 32'h8000_00B8, 32'h117, 4'b1000, 32'h7878_7878);
    store_step(32'h0011_1C23, "sh+0", 32'h8000_00BC, 32'h118, 4'b0011, 32'h5678_5678);
    store_step(32'h0011_1D23, "sh+2", 32'h8000_00C0, 32'h11A, 4'b1100, 32'h5678_5678);
    // ebreak, then nothing may commit
    plain_step(32'h0010_0073, "ebreak", 32'h8000_00C4, 1'b0);
    plain_step(32'h0011_2023, "sw halt", 32'h8000_00C4, 1'b1);
    plain_step(32'h0011_0A23, "sb halt", 32'h8000_00C4, 1'b1);
    plain_step(32'h1000_026F, "jal halt", 32'h8000_00C4, 1'b1);
  endtask

  initial begin
    int i;
    clk      = 1'b0;
    arst_n   = 1'b0;
    inst     = '0;
    check_en = 1'b0;
    done     = 1'b0;
    cur      = '0;
    cur_idx  = 0;
    fill     = 0;
    void'($urandom(seed));
    // random background, one known word at 0x120 for the loads
    for (i = 0; i < 16; i++) begin
      mem[i] <= $urandom;
    end
    mem[8] <= 32'hF13C_7F85;
    build_table();
    repeat (reset_cycles) @(posedge clk);
    #1 arst_n = 1'b1;
    for (i = 0; i < num_steps; i++) begin
      cur      = steps[i];
      cur_idx  = i;
      inst     = steps[i].inst;
      check_en = 1'b1;
      @(posedge clk);
      #1;
    end
    check_en = 1'b0;
    done     = 1'b1;
    #1;
    if (fail_count == 0 && pass_count == num_steps &&
        rv_core_top_i.pc_unit_i.pc_checks.fire_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
